// ==== source/core_pkg.sv ====
package core_pkg;

	// --------------------------------------------------
	// Widths and sizes

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [7:0] mem_addr_t;
	typedef logic [2:0] alu_op_t;

	localparam int REG_COUNT = 2 ** $bits(reg_idx_t);
	localparam int MEM_WORDS = 2 ** $bits(mem_addr_t);

	localparam int INST_BUF_DEPTH = 4; // Also the input credits owned by the source after reset
	localparam int INST_PTR_W = $clog2(INST_BUF_DEPTH);

	localparam int RESULT_CREDITS_MAX = 2; // Slots in the consumer's buffer
	localparam int RESULT_CREDIT_W = $clog2(RESULT_CREDITS_MAX + 1);

	// --------------------------------------------------
	// Instruction encodings

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLT = 3'd5;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// --------------------------------------------------
	// Stage records

	typedef struct packed {
		logic valid;
		alu_op_t alu_op;
		word_t operand_a;
		word_t operand_b;
		word_t store_data;
		reg_idx_t dest;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} ex_req_t;

	typedef struct packed {
		logic valid;
		word_t alu_result; // Byte address for loads and stores
		word_t store_data;
		reg_idx_t dest;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		word_t alu_result;
		word_t read_data;
		reg_idx_t dest;
		logic reg_write;
		logic mem_to_reg;
	} wb_req_t;

	typedef struct packed {
		reg_idx_t dest;
		word_t value;
	} result_t;

	typedef struct packed {
		logic en;
		reg_idx_t dest;
		word_t value;
	} reg_write_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_DONE
	} mem_state_t;

endpackage

// ==== source/data_memory.sv ====
`timescale 1ns/10ps

module data_memory
	import core_pkg::*;
(
	input logic CLK,
	input mem_addr_t addr,
	input word_t write_data,
	input logic mem_write,
	input logic mem_read,
	output word_t read_data
);
	word_t mem [MEM_WORDS];

	// --------------------------------------------------
	// Single port, write and read on the same edge

	always_ff @(posedge CLK) begin
		if (mem_write) begin
			mem[addr] <= write_data;
		end
	end

	// Read data stays put until the next read
	always_ff @(posedge CLK) begin
		if (mem_read) begin
			read_data <= mem[addr];
		end
	end

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode
	import core_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic inst_valid,
	input word_t inst,
	output logic inst_credit,
	input reg_write_t reg_write,
	input logic stall,
	output ex_req_t ex_req
);
	word_t inst_buf [INST_BUF_DEPTH];
	logic [INST_PTR_W-1:0] wr_ptr;
	logic [INST_PTR_W-1:0] rd_ptr;
	logic [INST_PTR_W:0] count;
	logic empty;
	logic full;
	logic issue;
	logic hazard;

	word_t rf [REG_COUNT];
	logic [REG_COUNT-1:0] busy;

	word_t head;
	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	word_t rs_value;
	word_t rt_value;
	word_t imm_ext;
	ex_req_t dec;

	// --------------------------------------------------
	// Instruction buffer

	assign empty = (count == '0);
	assign full = (count == INST_BUF_DEPTH);
	assign head = inst_buf[rd_ptr];

	always_ff @(posedge CLK) begin
		if (inst_valid) begin
			inst_buf[wr_ptr] <= inst;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			inst_credit <= 1'b0;
		end else begin
			if (inst_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (INST_PTR_W + 1)'(inst_valid) - (INST_PTR_W + 1)'(issue);
			inst_credit <= issue; // A freed slot goes back to the source
		end
	end

	// --------------------------------------------------
	// Field decode and register read

	assign opcode = head[31:26];
	assign rs = head[25:21];
	assign rt = head[20:16];
	assign rd = head[15:11];
	assign funct = head[5:0];
	assign imm_ext = {{16{head[15]}}, head[15:0]};

	assign rs_value = (rs == '0) ? '0 : rf[rs];
	assign rt_value = (rt == '0) ? '0 : rf[rt];

	always_comb begin
		dec = '0;
		dec.valid = 1'b1;
		dec.alu_op = ALU_ADD;
		dec.operand_a = rs_value;
		dec.operand_b = imm_ext; // Immediate forms and address calculation
		dec.store_data = rt_value;
		dec.dest = rt;
		case (opcode)
			OP_RTYPE: begin
				dec.operand_b = rt_value;
				dec.dest = rd;
				dec.reg_write = 1'b1;
				case (funct)
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR: dec.alu_op = ALU_OR;
					FN_XOR: dec.alu_op = ALU_XOR;
					FN_SLT: dec.alu_op = ALU_SLT;
					default: dec.reg_write = 1'b0; // Unknown funct retires as a no-op
				endcase
			end
			OP_ADDIU: dec.reg_write = 1'b1;
			OP_LW: begin
				dec.reg_write = 1'b1;
				dec.mem_read = 1'b1;
			end
			OP_SW: dec.mem_write = 1'b1;
			default: dec.reg_write = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// Scoreboard, issue and register file

	assign hazard = busy[rs] || busy[rt] || (dec.reg_write && busy[dec.dest]);
	assign issue = !empty && !hazard && !stall;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (reg_write.en) begin
				busy[reg_write.dest] <= 1'b0;
			end
			if (issue && dec.reg_write && (dec.dest != '0)) begin
				busy[dec.dest] <= 1'b1; // A new writer wins over a release of the same register
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rf <= '{default: '0};
		end else if (reg_write.en) begin
			rf[reg_write.dest] <= reg_write.value;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			ex_req.valid <= 1'b0;
		end else if (!stall) begin
			ex_req <= dec;
			ex_req.valid <= issue; // Bubble on a hazard
		end
	end

	a_push_with_credit: assert property (@(posedge CLK) disable iff (reset) inst_valid |-> !full)
		else $error("Instruction pushed without a credit");
	// The pointers must show a stored entry whenever the count lets the head go
	a_pop_not_empty: assert property (@(posedge CLK) disable iff (reset)
		issue |-> (rd_ptr != wr_ptr || full))
		else $error("Instruction buffer popped while empty");

endmodule

// ==== source/alu_execute.sv ====
`timescale 1ns/10ps

module alu_execute
	import core_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic stall,
	input ex_req_t ex_req,
	output mem_req_t mem_req
);
	word_t alu_result;
	logic less_than;

	// --------------------------------------------------
	// ALU

	assign less_than = $signed(ex_req.operand_a) < $signed(ex_req.operand_b);

	always_comb begin
		case (ex_req.alu_op)
			ALU_ADD: begin
				alu_result = ex_req.operand_a + ex_req.operand_b;
			end
			ALU_SUB: begin
				alu_result = ex_req.operand_a - ex_req.operand_b;
			end
			ALU_AND: begin
				alu_result = ex_req.operand_a & ex_req.operand_b;
			end
			ALU_OR: begin
				alu_result = ex_req.operand_a | ex_req.operand_b;
			end
			ALU_XOR: begin
				alu_result = ex_req.operand_a ^ ex_req.operand_b;
			end
			ALU_SLT: begin
				alu_result = word_t'(less_than);
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

	// --------------------------------------------------
	// Stage register toward memory access

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem_req.valid <= 1'b0;
		end else if (!stall) begin
			mem_req.valid <= ex_req.valid;
			mem_req.alu_result <= alu_result; // Doubles as the load or store address
			mem_req.store_data <= ex_req.store_data;
			mem_req.dest <= ex_req.dest;
			mem_req.reg_write <= ex_req.reg_write;
			mem_req.mem_read <= ex_req.mem_read;
			mem_req.mem_write <= ex_req.mem_write;
		end
	end

endmodule

// ==== source/memory_access.sv ====
`timescale 1ns/10ps

module memory_access
	import core_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic stall_wb,
	input mem_req_t mem_req,
	output logic stall_mem,
	output wb_req_t wb_req
);
	mem_state_t state;
	mem_req_t held;
	word_t mem_data;
	logic mem_op;
	logic start;

	assign mem_op = mem_req.valid && (mem_req.mem_read || mem_req.mem_write);
	assign start = (state == MEM_IDLE) && mem_op && !stall_wb;
	assign stall_mem = ((state == MEM_IDLE) && mem_op) || (state == MEM_WAIT);

	data_memory i_data_memory (
		.CLK(CLK),
		.addr(mem_req.alu_result[$bits(mem_addr_t)+1:2]), // Word address from the byte address
		.write_data(mem_req.store_data),
		.mem_write(start && mem_req.mem_write),
		.mem_read(start && mem_req.mem_read),
		.read_data(mem_data)
	);

	// --------------------------------------------------
	// Load/store sequencer

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= MEM_IDLE;
			wb_req.valid <= 1'b0;
		end else begin
			if (start) begin
				held <= mem_req;
			end
			case (state)
				MEM_IDLE: begin
					if (!stall_wb) begin
						wb_req.valid <= mem_req.valid && !mem_op; // ALU results pass straight on
						wb_req.alu_result <= mem_req.alu_result;
						wb_req.read_data <= '0;
						wb_req.dest <= mem_req.dest;
						wb_req.reg_write <= mem_req.reg_write;
						wb_req.mem_to_reg <= 1'b0;
					end
					if (start) begin
						state <= MEM_WAIT;
					end
				end
				MEM_WAIT: begin
					if (!stall_wb) begin
						wb_req.valid <= 1'b0;
					end
					state <= MEM_DONE;
				end
				MEM_DONE: begin
					if (!stall_wb) begin
						wb_req.valid <= held.valid;
						wb_req.alu_result <= held.alu_result;
						wb_req.read_data <= mem_data;
						wb_req.dest <= held.dest;
						wb_req.reg_write <= held.reg_write;
						wb_req.mem_to_reg <= held.mem_read;
						state <= MEM_IDLE;
					end
				end
				default: begin
					state <= MEM_IDLE;
				end
			endcase
		end
	end

	// Decode never marks one instruction as both load and store
	a_single_mem_op: assert property (@(posedge CLK) disable iff (reset)
		mem_req.valid |-> !(mem_req.mem_read && mem_req.mem_write))
		else $error("Load and store requested together");

endmodule

// ==== source/writeback_result.sv ====
`timescale 1ns/10ps

module writeback_result
	import core_pkg::*;
(
	input logic CLK,
	input logic reset,
	input wb_req_t wb_req,
	input logic result_credit,
	output logic stall_wb,
	output reg_write_t reg_write,
	output logic result_valid,
	output result_t result
);
	logic [RESULT_CREDIT_W-1:0] credits;
	logic has_result;
	logic send;
	word_t value;

	assign value = wb_req.mem_to_reg ? wb_req.read_data : wb_req.alu_result;
	assign has_result = wb_req.valid && wb_req.reg_write && (wb_req.dest != '0);
	assign send = has_result && (credits != '0);
	assign stall_wb = has_result && (credits == '0); // Hold the request until a credit returns

	// --------------------------------------------------
	// Output credits, result and register write

	always_ff @(posedge CLK) begin
		if (reset) begin
			credits <= RESULT_CREDIT_W'(RESULT_CREDITS_MAX);
			result_valid <= 1'b0;
			reg_write.en <= 1'b0;
		end else begin
			credits <= credits - RESULT_CREDIT_W'(send) + RESULT_CREDIT_W'(result_credit);
			result_valid <= send;
			reg_write.en <= send;
			if (send) begin
				result.dest <= wb_req.dest;
				result.value <= value;
				reg_write.dest <= wb_req.dest;
				reg_write.value <= value;
			end
		end
	end

	// The consumer never returns more credits than it has slots
	a_credit_bound: assert property (@(posedge CLK) disable iff (reset)
		credits <= RESULT_CREDITS_MAX)
		else $error("Output credit count above the consumer buffer size");

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/10ps

module core_top
	import core_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic inst_valid,
	input word_t inst,
	output logic inst_credit,
	output logic result_valid,
	output result_t result,
	input logic result_credit
);
	ex_req_t ex_req;
	mem_req_t mem_req;
	wb_req_t wb_req;
	reg_write_t reg_write;
	logic stall_mem;
	logic stall_wb;
	logic stall;

	assign stall = stall_mem | stall_wb; // Freezes decode and execute

	inst_decode i_inst_decode (
		.CLK(CLK),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_credit(inst_credit),
		.reg_write(reg_write),
		.stall(stall),
		.ex_req(ex_req)
	);

	alu_execute i_alu_execute (
		.CLK(CLK),
		.reset(reset),
		.stall(stall),
		.ex_req(ex_req),
		.mem_req(mem_req)
	);

	memory_access i_memory_access (
		.CLK(CLK),
		.reset(reset),
		.stall_wb(stall_wb),
		.mem_req(mem_req),
		.stall_mem(stall_mem),
		.wb_req(wb_req)
	);

	writeback_result i_writeback_result (
		.CLK(CLK),
		.reset(reset),
		.wb_req(wb_req),
		.result_credit(result_credit),
		.stall_wb(stall_wb),
		.reg_write(reg_write),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

// ==== bench/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// --------------------------------------------------
// Architectural state, updated in program order

word_t model_rf [REG_COUNT] = '{default: '0};
word_t model_mem [MEM_WORDS];
logic model_written [MEM_WORDS] = '{default: 1'b0}; // Random loads only target stored words
result_t expected_q [$];

function automatic word_t encode_r(input logic [5:0] funct, input int rd, input int rs,
	input int rt);
	return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

function automatic word_t encode_i(input logic [5:0] opcode, input int rt, input int rs,
	input logic [15:0] imm);
	return {opcode, 5'(rs), 5'(rt), imm};
endfunction

// --------------------------------------------------
// Reference execution of one instruction

function automatic void model_execute(input word_t word);
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t dest;
	word_t a;
	word_t b;
	word_t offset;
	word_t value;
	logic [7:0] index;
	logic writes;
	result_t entry;
	rs = word[25:21];
	rt = word[20:16];
	a = (rs == 0) ? '0 : model_rf[rs];
	b = (rt == 0) ? '0 : model_rf[rt];
	offset = {{16{word[15]}}, word[15:0]};
	index = 8'((a + offset) >> 2); // Byte address to word slot
	dest = rt;
	value = '0;
	writes = 1'b1;
	case (word[31:26])
		OP_RTYPE: begin
			dest = word[15:11];
			case (word[5:0])
				FN_ADDU: value = a + b;
				FN_SUBU: value = a - b;
				FN_AND: value = a & b;
				FN_OR: value = a | b;
				FN_XOR: value = a ^ b;
				FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: writes = 1'b0;
			endcase
		end
		OP_ADDIU: value = a + offset;
		OP_LW: value = model_mem[index];
		OP_SW: begin
			model_mem[index] = b;
			model_written[index] = 1'b1;
			writes = 1'b0;
		end
		default: writes = 1'b0; // Anything else retires silently
	endcase
	if (writes && dest != 0) begin
		model_rf[dest] = value;
		entry.dest = dest;
		entry.value = value;
		expected_q.push_back(entry);
	end
endfunction

`endif

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb
	import core_pkg::*;
();
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_COUNT = 300;
	localparam int CYCLES_PER_INST = 40;
	localparam int DRAIN_CYCLES = 32;
	localparam int MEM_POOL = 16; // Words touched by random loads and stores

	logic CLK;
	logic reset;
	logic inst_valid;
	word_t inst;
	logic inst_credit;
	logic result_valid;
	result_t result;
	logic result_credit;

	logic [31:0] rng_state = 32'd61183;
	logic program_ready = 1'b0;
	word_t program_q [$];
	int expected_total;
	int results_seen = 0;

	`include "core_model.svh"

	core_top i_dut (
		.CLK(CLK),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_credit(inst_credit),
		.result_valid(result_valid),
		.result(result),
		.result_credit(result_credit)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) CLK = ~CLK;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic void append_instruction(input word_t word);
		program_q.push_back(word);
		model_execute(word);
	endfunction

	// --------------------------------------------------
	// Program construction

	function automatic void add_directed_tests();
		append_instruction(encode_i(OP_ADDIU, 1, 0, 16'd100));
		append_instruction(encode_i(OP_ADDIU, 2, 0, 16'hfff9)); // Minus seven
		append_instruction(encode_i(OP_ADDIU, 3, 0, 16'h7fff));
		append_instruction(encode_r(FN_ADDU, 4, 1, 2));
		append_instruction(encode_r(FN_SUBU, 5, 2, 1));
		append_instruction(encode_r(FN_AND, 6, 2, 3));
		append_instruction(encode_r(FN_OR, 7, 1, 3));
		append_instruction(encode_r(FN_XOR, 8, 2, 3));
		append_instruction(encode_r(FN_SLT, 9, 2, 1)); // Negative below positive
		append_instruction(encode_r(FN_SLT, 10, 1, 2));
		append_instruction(encode_r(FN_ADDU, 0, 1, 1));
		append_instruction(encode_i(OP_ADDIU, 0, 1, 16'd5));
		append_instruction(encode_i(6'h0f, 11, 1, 16'd5)); // Opcode outside the subset
		append_instruction(encode_r(6'h00, 12, 1, 2));
		append_instruction(encode_r(FN_ADDU, 13, 0, 1));
		// Stores then loads, several addresses and an overwrite
		append_instruction(encode_i(OP_SW, 1, 0, 16'd0));
		append_instruction(encode_i(OP_SW, 2, 0, 16'd4));
		append_instruction(encode_i(OP_SW, 8, 0, 16'd1020));
		append_instruction(encode_i(OP_LW, 14, 0, 16'd0));
		append_instruction(encode_i(OP_LW, 15, 0, 16'd4));
		append_instruction(encode_i(OP_LW, 16, 0, 16'd1020));
		append_instruction(encode_i(OP_SW, 5, 0, 16'd0));
		append_instruction(encode_i(OP_LW, 17, 0, 16'd0));
		append_instruction(encode_i(OP_ADDIU, 18, 0, 16'd16));
		append_instruction(encode_i(OP_SW, 9, 18, 16'd8)); // Base register plus offset
		append_instruction(encode_i(OP_LW, 19, 0, 16'd24));
		// Back-to-back dependencies
		append_instruction(encode_i(OP_ADDIU, 20, 0, 16'd3));
		append_instruction(encode_r(FN_ADDU, 20, 20, 20));
		append_instruction(encode_r(FN_ADDU, 20, 20, 20));
		append_instruction(encode_r(FN_SUBU, 21, 20, 1));
		append_instruction(encode_r(FN_SLT, 22, 21, 20));
		append_instruction(encode_i(OP_LW, 23, 0, 16'd4));
		append_instruction(encode_r(FN_XOR, 24, 23, 20)); // Load then use
		append_instruction(encode_i(OP_SW, 24, 0, 16'd40));
		append_instruction(encode_i(OP_LW, 25, 0, 16'd40));
		append_instruction(encode_i(OP_ADDIU, 25, 25, 16'd1));
	endfunction

	function automatic void add_random_program(input int count);
		int i;
		int kind;
		int rd;
		int rs;
		int rt;
		int slot;
		logic [5:0] funct;
		for (i = 0; i < count; i++) begin
			kind = int'(next_random() % 10);
			rd = int'(next_random() % 32);
			rs = int'(next_random() % 32);
			rt = int'(next_random() % 32);
			slot = int'(next_random() % MEM_POOL);
			case (int'(next_random() % 7))
				0: funct = FN_ADDU;
				1: funct = FN_SUBU;
				2: funct = FN_AND;
				3: funct = FN_OR;
				4: funct = FN_XOR;
				5: funct = FN_SLT;
				default: funct = 6'h00;
			endcase
			if (kind < 5) begin
				append_instruction(encode_r(funct, rd, rs, rt));
			end else if (kind < 7) begin
				append_instruction(encode_i(OP_ADDIU, rt, rs, 16'(next_random())));
			end else if (kind == 7 && model_written[slot]) begin
				append_instruction(encode_i(OP_LW, rt, 0, 16'(slot * 4)));
			end else if (kind < 9) begin
				append_instruction(encode_i(OP_SW, rt, 0, 16'(slot * 4)));
			end else begin
				append_instruction(encode_i(6'h0f, rt, rs, 16'(next_random())));
			end
		end
	endfunction

	// --------------------------------------------------
	// Source side, with its credit count

	initial begin : run_program
		int credits;
		int idx;
		int cycles;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		add_directed_tests();
		add_random_program(RANDOM_COUNT);
		expected_total = expected_q.size();
		program_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		reset <= 1'b0;
		credits = INST_BUF_DEPTH;
		idx = 0;
		cycles = 0;
		while (idx < program_q.size() || results_seen < expected_total || cycles < DRAIN_CYCLES) begin
			@(posedge CLK);
			if (inst_credit) begin
				credits++;
			end
			assert (credits >= 0 && credits <= INST_BUF_DEPTH)
				else abort_run($sformatf("Source holds %0d input credits at %0t, outside 0 to %0d",
					credits, $time, INST_BUF_DEPTH));
			if (idx < program_q.size() && credits > 0) begin
				inst_valid <= 1'b1;
				inst <= program_q[idx];
				credits--;
				idx++;
			end else begin
				inst_valid <= 1'b0;
			end
			if (idx == program_q.size() && results_seen == expected_total) begin
				cycles++;
			end
		end
		if (expected_q.size() == 0 && credits == INST_BUF_DEPTH) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run($sformatf("Run ended with %0d results missing and %0d of %0d input credits back",
				expected_q.size(), credits, INST_BUF_DEPTH));
		end
	end

	// --------------------------------------------------
	// Consumer side and comparison

	initial begin : return_result_credits
		int cycle;
		int due;
		int last_due;
		int due_q [$];
		result_credit = 1'b0;
		cycle = 0;
		last_due = 0;
		forever begin
			@(posedge CLK);
			cycle++;
			if (!reset && result_valid) begin
				due = cycle + 1 + int'(next_random() % 12); // Slow consumer frees its slot late
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				due_q.push_back(due);
			end
			if (due_q.size() != 0 && due_q[0] <= cycle) begin
				void'(due_q.pop_front());
				result_credit <= 1'b1;
			end else begin
				result_credit <= 1'b0;
			end
		end
	end

	always @(posedge CLK) begin : compare_results
		result_t expected_entry;
		if (!reset && result_valid) begin
			assert (expected_q.size() != 0)
				else abort_run($sformatf("Result for r%0d at %0t arrived with none expected",
					result.dest, $time));
			expected_entry = expected_q.pop_front();
			assert (result == expected_entry)
				else abort_run($sformatf("Mismatch at %0t: result expected r%0d=%h, got r%0d=%h",
					$time, expected_entry.dest, expected_entry.value, result.dest, result.value));
			results_seen <= results_seen + 1;
		end
	end

	initial begin : watchdog
		wait (program_ready);
		repeat (RESET_CYCLES + CYCLES_PER_INST * program_q.size()) @(posedge CLK);
		abort_run($sformatf("Timeout with %0d of %0d results seen", results_seen, expected_total));
	end

endmodule

// ==== list.f ====
+incdir+bench
source/core_pkg.sv
source/data_memory.sv
source/inst_decode.sv
source/alu_execute.sv
source/memory_access.sv
source/writeback_result.sv
source/core_top.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = core_tb
FILELIST = list.f
OBJ_DIR = obj_dir
LOG = sim.log

BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) bench/core_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation reported an error"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
